// ==== src/pe_row_params.svh ====
`ifndef PE_ROW_PARAMS_SVH
`define PE_ROW_PARAMS_SVH

// word widths of the datapath.
`define PE_ACT_W 8
`define PE_ACC_W 32

// default number of PEs in one row.
`define PE_NUM_PE 4

// register map, byte addresses.
`define PE_ADDR_CTRL 4'h0
`define PE_ADDR_SHIFT 4'h4
`define PE_ADDR_BIAS 4'h8

`endif

// ==== src/pe_types_pkg.sv ====
`default_nettype none

`include "pe_row_params.svh"

package pe_types_pkg;

	// element precision; 3 is decoded like the 4-bit mode.
	typedef enum logic [1:0] {
		PREC_8B = 2'd0,
		PREC_4B = 2'd1,
		PREC_2B = 2'd2
	} precision_e;

	// configuration shared by all PEs of the row
	typedef struct packed {
		precision_e precision;
		logic relu_en;
		logic shift_en;
		logic [4:0] shift; // arithmetic right shift amount.
		logic signed [`PE_ACC_W-1:0] bias; // start value of each vector.
	} pe_cfg_t;

	typedef struct packed {
		logic valid;
		logic last; // final beat of a vector.
		logic [`PE_ACT_W-1:0] act; // broadcast to every PE.
		logic [`PE_NUM_PE-1:0][`PE_ACT_W-1:0] weight; // one word per PE.
	} row_beat_t;

	typedef struct packed {
		logic valid;
		logic [`PE_NUM_PE-1:0][`PE_ACC_W-1:0] value;
	} row_result_t;

endpackage

`default_nettype wire

// ==== src/axi_lite_pkg.sv ====
`default_nettype none

package axi_lite_pkg;

	localparam logic [1:0] AXIL_OKAY = 2'd0;
	localparam logic [1:0] AXIL_SLVERR = 2'd2;

	// manager to subordinate.
	typedef struct packed {
		logic awvalid;
		logic [3:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		logic [3:0] araddr;
		logic rready;
	} axil_req_t;

	// subordinate to manager.
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire

// ==== src/scalable_mult.sv ====
`default_nettype none

`include "pe_row_params.svh"

module scalable_mult import pe_types_pkg::*; (
	input logic signed [`PE_ACT_W-1:0] act,
	input logic signed [`PE_ACT_W-1:0] weight,
	input precision_e precision,
	output logic signed [2*`PE_ACT_W:0] product
);

	localparam int HALF_W = `PE_ACT_W / 2;
	localparam int QUART_W = `PE_ACT_W / 4;

	logic signed [2*`PE_ACT_W-1:0] prod_full;
	logic signed [2*HALF_W-1:0] prod_half [2];
	logic signed [2*QUART_W-1:0] prod_quart [4];
	logic signed [2*`PE_ACT_W:0] sum_half;
	logic signed [2*`PE_ACT_W:0] sum_quart;

	// lane i of act always meets lane i of weight.
	always_comb begin
		prod_full = act * weight;
		for (int i = 0; i < 2; i++) begin
			prod_half[i] = $signed(act[HALF_W*i +: HALF_W]) *
				$signed(weight[HALF_W*i +: HALF_W]);
		end
		for (int i = 0; i < 4; i++) begin
			prod_quart[i] = $signed(act[QUART_W*i +: QUART_W]) *
				$signed(weight[QUART_W*i +: QUART_W]);
		end
	end

	// lane sums, sign-extended to the product width.
	always_comb begin
		sum_half = prod_half[0] + prod_half[1];
		sum_quart = prod_quart[0] + prod_quart[1] + prod_quart[2] + prod_quart[3];
	end

	always_comb begin
		case (precision)
			PREC_8B: begin
				product = prod_full;
			end
			PREC_2B: begin
				product = sum_quart;
			end
			default: begin
				product = sum_half; // 4-bit lanes, also code 3.
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/pe.sv ====
`default_nettype none

`include "pe_row_params.svh"

module pe import pe_types_pkg::*; (
	input logic clk,
	input logic reset,
	input pe_cfg_t cfg,
	input logic valid,
	input logic last,
	input logic [`PE_ACT_W-1:0] act,
	input logic [`PE_ACT_W-1:0] weight,
	output logic done,
	output logic signed [`PE_ACC_W-1:0] result
);

	logic signed [2*`PE_ACT_W:0] product;
	logic signed [`PE_ACC_W-1:0] acc;
	logic signed [`PE_ACC_W-1:0] acc_base;
	logic first_beat;
	logic done_q;

	logic signed [`PE_ACC_W-1:0] shifted;
	logic signed [`PE_ACC_W-1:0] sat_max;
	logic signed [`PE_ACC_W-1:0] sat_min;
	logic signed [`PE_ACT_W-1:0] sat_elem;
	int unsigned elem_w;

	scalable_mult i_mult (
		.act(act),
		.weight(weight),
		.precision(cfg.precision),
		.product(product)
	);

	// a vector starts from the bias, not from the previous sum.
	assign acc_base = first_beat ? cfg.bias : acc;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			first_beat <= 1'b1;
			done_q <= 1'b0;
		end else begin
			done_q <= valid & last;
			if (valid) begin
				first_beat <= last; // the beat after last opens a new vector.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (valid) begin
			acc <= acc_base + product;
		end
	end

	// element width of the active precision.
	always_comb begin
		case (cfg.precision)
			PREC_8B: elem_w = `PE_ACT_W;
			PREC_2B: elem_w = `PE_ACT_W / 4;
			default: elem_w = `PE_ACT_W / 2;
		endcase
		sat_max = (`PE_ACC_W'sd1 <<< (elem_w - 1)) - `PE_ACC_W'sd1;
		sat_min = -(`PE_ACC_W'sd1 <<< (elem_w - 1));
	end

	always_comb begin
		shifted = cfg.shift_en ? (acc >>> cfg.shift) : acc;
		if (shifted > sat_max) begin
			sat_elem = sat_max[`PE_ACT_W-1:0];
		end else if (shifted < sat_min) begin
			sat_elem = sat_min[`PE_ACT_W-1:0];
		end else begin
			sat_elem = shifted[`PE_ACT_W-1:0];
		end
		if (cfg.relu_en && sat_elem[`PE_ACT_W-1]) begin
			sat_elem = '0;
		end
	end

	assign result = sat_elem; // sign-extends to the accumulator width.
	assign done = done_q;

endmodule

`default_nettype wire

// ==== src/pe_csr.sv ====
`default_nettype none

`include "pe_row_params.svh"

module pe_csr import pe_types_pkg::*, axi_lite_pkg::*; (
	input logic clk,
	input logic reset,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output pe_cfg_t cfg
);

	logic wr_accept;
	logic rd_accept;
	logic bvalid_q;
	logic rvalid_q;
	logic [1:0] bresp_q;
	logic [1:0] rresp_q;
	logic [31:0] rdata_q;
	logic [1:0] prec_q;
	logic relu_q;
	logic shift_en_q;
	logic [4:0] shift_q;
	logic [`PE_ACC_W-1:0] bias_q;
	logic [31:0] ctrl_word;
	logic [31:0] shift_word;
	logic [31:0] ctrl_next;
	logic [31:0] shift_next;
	logic [31:0] bias_next;
	logic wr_known;
	logic [31:0] rd_word;
	logic rd_known;

	function automatic logic [31:0] merge_strb(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] merged;
		merged = old_val;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				merged[8*b +: 8] = new_val[8*b +: 8];
			end
		end
		return merged;
	endfunction

	assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
	assign rd_accept = axil_req.arvalid & ~rvalid_q;

	assign ctrl_word = {26'd0, shift_en_q, relu_q, 2'd0, prec_q};
	assign shift_word = {27'd0, shift_q};
	assign ctrl_next = merge_strb(ctrl_word, axil_req.wdata, axil_req.wstrb);
	assign shift_next = merge_strb(shift_word, axil_req.wdata, axil_req.wstrb);
	assign bias_next = merge_strb(bias_q, axil_req.wdata, axil_req.wstrb);
	assign wr_known = axil_req.awaddr inside {`PE_ADDR_CTRL, `PE_ADDR_SHIFT, `PE_ADDR_BIAS};

	always_comb begin
		rd_known = 1'b1;
		case (axil_req.araddr)
			`PE_ADDR_CTRL: rd_word = ctrl_word;
			`PE_ADDR_SHIFT: rd_word = shift_word;
			`PE_ADDR_BIAS: rd_word = bias_q;
			default: begin
				rd_word = '0;
				rd_known = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			bresp_q <= AXIL_OKAY;
			rresp_q <= AXIL_OKAY;
			prec_q <= '0;
			relu_q <= 1'b0;
			shift_en_q <= 1'b0;
			shift_q <= '0;
			bias_q <= '0;
		end else begin
			if (wr_accept) begin
				bvalid_q <= 1'b1;
				bresp_q <= wr_known ? AXIL_OKAY : AXIL_SLVERR;
				case (axil_req.awaddr)
					`PE_ADDR_CTRL: begin
						prec_q <= ctrl_next[1:0];
						relu_q <= ctrl_next[4];
						shift_en_q <= ctrl_next[5];
					end
					`PE_ADDR_SHIFT: shift_q <= shift_next[4:0];
					`PE_ADDR_BIAS: bias_q <= bias_next;
					default: ; // unknown address writes nothing.
				endcase
			end else if (axil_req.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_accept) begin
				rvalid_q <= 1'b1;
				rresp_q <= rd_known ? AXIL_OKAY : AXIL_SLVERR;
			end else if (axil_req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rdata_q <= rd_word;
		end
	end

	always_comb begin
		axil_rsp.awready = wr_accept;
		axil_rsp.wready = wr_accept;
		axil_rsp.bvalid = bvalid_q;
		axil_rsp.bresp = bresp_q;
		axil_rsp.arready = rd_accept;
		axil_rsp.rvalid = rvalid_q;
		axil_rsp.rdata = rdata_q;
		axil_rsp.rresp = rresp_q;
	end

	always_comb begin
		cfg.precision = precision_e'(prec_q);
		cfg.relu_en = relu_q;
		cfg.shift_en = shift_en_q;
		cfg.shift = shift_q;
		cfg.bias = bias_q;
	end

endmodule

`default_nettype wire

// ==== src/pe_row.sv ====
`default_nettype none

`include "pe_row_params.svh"

module pe_row import pe_types_pkg::*, axi_lite_pkg::*; #(
	parameter int NUM_PE = `PE_NUM_PE // at most the width of the beat struct.
) (
	input logic clk,
	input logic reset,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input row_beat_t beat,
	output row_result_t result
);

	pe_cfg_t cfg;
	logic [NUM_PE-1:0] pe_done;
	logic signed [`PE_ACC_W-1:0] pe_result [NUM_PE];

	pe_csr i_csr (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.cfg(cfg)
	);

	for (genvar g = 0; g < NUM_PE; g++) begin : g_pe
		pe i_pe (
			.clk(clk),
			.reset(reset),
			.cfg(cfg),
			.valid(beat.valid),
			.last(beat.last),
			.act(beat.act),
			.weight(beat.weight[g]),
			.done(pe_done[g]),
			.result(pe_result[g])
		);
	end

	// all PEs step in lockstep, so PE 0 stands for the row.
	always_comb begin
		result.valid = pe_done[0];
		result.value = '0;
		for (int i = 0; i < NUM_PE; i++) begin
			result.value[i] = pe_result[i];
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b0; // active low.
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/tb_pe_row.sv ====
`default_nettype none

`include "pe_row_params.svh"

module tb_pe_row import pe_types_pkg::*, axi_lite_pkg::*; ();

	localparam int NUM_TESTS = 7;
	localparam int MAX_LEN = 8;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_LEN * 40 + 400;

	typedef struct {
		string name;
		logic [1:0] prec;
		logic relu_en;
		logic shift_en;
		logic [4:0] shift;
		int bias;
		int len; // longest vector of the row.
		int vecs; // vectors sent back to back.
		bit gaps; // invalid beats between valid ones.
		bit exp_err;
	} test_row_t;

	logic clk;
	logic reset;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	row_beat_t beat;
	row_result_t result;
	test_row_t tests [NUM_TESTS];
	logic [31:0] rnd_state;
	int test_errors;
	int passed;
	int failed;

	tb_clk_gen #(.PERIOD(20), .RESET_CYCLES(2)) i_clk_gen (.clk(clk), .reset(reset));

	pe_row #(.NUM_PE(4)) i_dut (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.beat(beat),
		.result(result)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic int elem_width(input logic [1:0] prec);
		return (prec == 2'd0) ? 8 : ((prec == 2'd2) ? 2 : 4);
	endfunction

	// sum of lane products, lane i of a against lane i of w.
	function automatic int lane_dot(input logic [7:0] a, input logic [7:0] w,
		input logic [1:0] prec);
		int lw;
		int la;
		int lb;
		int sum;
		lw = elem_width(prec);
		sum = 0;
		for (int i = 0; i < 8 / lw; i++) begin
			la = (a >> (i * lw)) & ((1 << lw) - 1);
			lb = (w >> (i * lw)) & ((1 << lw) - 1);
			if (la >= (1 << (lw - 1)))
				la -= (1 << lw);
			if (lb >= (1 << (lw - 1)))
				lb -= (1 << lw);
			sum += la * lb;
		end
		return sum;
	endfunction

	function automatic int finish_value(input int acc, input test_row_t t);
		int lw;
		int v;
		lw = elem_width(t.prec);
		v = t.shift_en ? (acc >>> t.shift) : acc;
		if (v > (1 << (lw - 1)) - 1)
			v = (1 << (lw - 1)) - 1;
		else if (v < -(1 << (lw - 1)))
			v = -(1 << (lw - 1));
		if (t.relu_en && v < 0)
			v = 0;
		return v;
	endfunction

	function automatic row_beat_t random_beat(input logic valid, input logic last);
		row_beat_t b;
		rnd_state = xorshift32(rnd_state);
		b.weight = rnd_state;
		rnd_state = xorshift32(rnd_state);
		b.act = rnd_state[7:0];
		b.valid = valid;
		b.last = last | (~valid & rnd_state[8]); // stray last on idle beats.
		return b;
	endfunction

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr <= addr;
		axil_req.wvalid <= 1'b1;
		axil_req.wdata <= data;
		axil_req.wstrb <= strb;
		@(negedge clk);
		while (!axil_rsp.awready)
			@(negedge clk);
		if (axil_rsp.wready !== 1'b1) begin
			$display("FAILED write_reg: wready got 0x%h expected 0x1", axil_rsp.wready);
			test_errors++;
		end
		@(posedge clk);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		axil_req.bready <= 1'b1;
		@(negedge clk);
		while (!axil_rsp.bvalid)
			@(negedge clk);
		resp = axil_rsp.bresp;
		@(posedge clk);
		axil_req.bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr <= addr;
		@(negedge clk);
		while (!axil_rsp.arready)
			@(negedge clk);
		@(posedge clk);
		axil_req.arvalid <= 1'b0;
		axil_req.rready <= 1'b1;
		@(negedge clk);
		while (!axil_rsp.rvalid)
			@(negedge clk);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clk);
		axil_req.rready <= 1'b0;
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s with %0d errors", name, test_errors);
			failed++;
		end
	endtask

	task automatic csr_test();
		logic [1:0] resp;
		logic [31:0] data;
		test_errors = 0;
		write_reg(`PE_ADDR_CTRL, 32'hffff_ffff, 4'hf, resp);
		read_reg(`PE_ADDR_CTRL, data, resp);
		if (data !== 32'h0000_0033) begin
			$display("FAILED csr_access: rdata got 0x%h expected 0x%h", data, 32'h33);
			test_errors++;
		end
		write_reg(`PE_ADDR_SHIFT, 32'hffff_ffff, 4'hf, resp);
		read_reg(`PE_ADDR_SHIFT, data, resp);
		if (data !== 32'h0000_001f) begin
			$display("FAILED csr_access: rdata got 0x%h expected 0x%h", data, 32'h1f);
			test_errors++;
		end
		write_reg(`PE_ADDR_BIAS, 32'h1122_3344, 4'hf, resp);
		write_reg(`PE_ADDR_BIAS, 32'haabb_ccdd, 4'b0101, resp); // bytes 0 and 2 only.
		read_reg(`PE_ADDR_BIAS, data, resp);
		if (data !== 32'h11bb_33dd) begin
			$display("FAILED csr_access: rdata got 0x%h expected 0x%h", data, 32'h11bb_33dd);
			test_errors++;
		end
		close_test("csr_access");
	endtask

	task automatic run_test(input test_row_t t);
		row_beat_t beats [$];
		row_beat_t b;
		int acc [`PE_NUM_PE];
		int exp_q [$];
		int n;
		logic [31:0] exp_val;
		logic [31:0] data;
		logic [1:0] resp;
		logic prev_last;
		test_errors = 0;
		write_reg(`PE_ADDR_CTRL, {26'd0, t.shift_en, t.relu_en, 2'd0, t.prec}, 4'hf, resp);
		write_reg(`PE_ADDR_SHIFT, {27'd0, t.shift}, 4'hf, resp);
		write_reg(`PE_ADDR_BIAS, t.bias, 4'hf, resp);
		if (t.exp_err) begin
			write_reg(4'hc, 32'hffff_ffff, 4'hf, resp);
			if (resp !== AXIL_SLVERR) begin
				$display("FAILED %s: bresp got 0x%h expected 0x%h", t.name, resp, AXIL_SLVERR);
				test_errors++;
			end
			read_reg(4'hc, data, resp);
			if (resp !== AXIL_SLVERR || data !== 32'h0) begin
				$display("FAILED %s: rresp got 0x%h expected 0x%h, rdata got 0x%h expected 0x0",
					t.name, resp, AXIL_SLVERR, data);
				test_errors++;
			end
		end
		for (int v = 0; v < t.vecs; v++) begin
			rnd_state = xorshift32(rnd_state);
			n = 1 + rnd_state % t.len;
			for (int i = 0; i < `PE_NUM_PE; i++)
				acc[i] = t.bias;
			for (int k = 0; k < n; k++) begin
				rnd_state = xorshift32(rnd_state);
				if (t.gaps && rnd_state[0])
					beats.push_back(random_beat(1'b0, 1'b0));
				b = random_beat(1'b1, k == n - 1);
				beats.push_back(b);
				for (int i = 0; i < `PE_NUM_PE; i++)
					acc[i] += lane_dot(b.act, b.weight[i], t.prec);
			end
			for (int i = 0; i < `PE_NUM_PE; i++)
				exp_q.push_back(finish_value(acc[i], t));
		end
		prev_last = 1'b0;
		for (int k = 0; k <= beats.size(); k++) begin
			@(posedge clk);
			beat <= (k < beats.size()) ? beats[k] : row_beat_t'(0);
			@(negedge clk); // the beat of k - 1 was sampled at this edge.
			if (prev_last && result.valid !== 1'b1) begin
				$display("%s: the result was missing in the cycle after the last beat", t.name);
				test_errors++;
			end else if (!prev_last && result.valid !== 1'b0) begin
				$display("FAILED %s: result.valid got 0x%h expected 0x0", t.name, result.valid);
				test_errors++;
			end
			if (prev_last) begin
				for (int i = 0; i < `PE_NUM_PE; i++) begin
					exp_val = exp_q.pop_front();
					if (result.value[i] !== exp_val) begin
						$display("FAILED %s: result.value[%0d] got 0x%h expected 0x%h",
							t.name, i, result.value[i], exp_val);
						test_errors++;
					end
				end
			end
			prev_last = (k < beats.size()) && beats[k].valid && beats[k].last;
		end
		close_test(t.name);
	endtask

	initial begin
		#(TIMEOUT_CYCLES * 20);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failures found");
		$finish;
	end

	initial begin
		axil_req = '0;
		beat = '0;
		rnd_state = 32'h0c19_0042;
		passed = 0;
		failed = 0;
		tests[0] = '{"int8_dot", 2'd0, 1'b0, 1'b0, 5'd0, 20, 8, 3, 1'b1, 1'b0};
		tests[1] = '{"int4_dot", 2'd1, 1'b0, 1'b0, 5'd0, -2, 6, 2, 1'b0, 1'b0};
		tests[2] = '{"int2_dot", 2'd2, 1'b0, 1'b0, 5'd0, 1, 8, 2, 1'b1, 1'b0};
		tests[3] = '{"shift_big_bias", 2'd0, 1'b0, 1'b1, 5'd10, 16384, 4, 1, 1'b0, 1'b0};
		tests[4] = '{"relu_neg_bias", 2'd0, 1'b1, 1'b0, 5'd0, -100000, 4, 1, 1'b0, 1'b0};
		tests[5] = '{"back_to_back", 2'd1, 1'b0, 1'b0, 5'd0, 3, 5, 3, 1'b0, 1'b0};
		tests[6] = '{"bad_address", 2'd2, 1'b0, 1'b0, 5'd0, -1, 3, 1, 1'b0, 1'b1};
		wait (reset === 1'b1);
		csr_test();
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(tests[t]);
		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== pe_row.f ====
+incdir+src
src/pe_types_pkg.sv
src/axi_lite_pkg.sv
src/scalable_mult.sv
src/pe.sv
src/pe_csr.sv
src/pe_row.sv
tb/tb_clk_gen.sv
tb/tb_pe_row.sv

// ==== Bender.yml ====
package:
  name: pe_row

sources:
  - include_dirs:
      - src
    files:
      - src/pe_types_pkg.sv
      - src/axi_lite_pkg.sv
      - src/scalable_mult.sv
      - src/pe.sv
      - src/pe_csr.sv
      - src/pe_row.sv

  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_pe_row.sv
